// File: rtl/dispatch_pkg.sv
package dispatch_pkg;

    //////////////////////////////////////////////////
    // Queue sizing
    //////////////////////////////////////////////////

    // Decode starts with this many credits
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;

    // Occupancy runs from 0 to QUEUE_DEPTH inclusive
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    localparam int PC_W       = 32;
    localparam int REG_ADDR_W = 5;

    // Register r0 is hardwired, never a real dependency
    localparam logic [REG_ADDR_W-1:0] REG_ZERO = '0;

    // Coarse class from the predecoder
    typedef enum logic [2:0] {
        CLASS_ALU    = 3'd0,
        CLASS_MULDIV = 3'd1,
        CLASS_LOAD   = 3'd2,
        CLASS_STORE  = 3'd3,
        CLASS_BRANCH = 3'd4
    } inst_class_e;

    //////////////////////////////////////////////////
    // Slot and pair
    //////////////////////////////////////////////////

    // One predecoded instruction, 50 bits
    typedef struct packed {
        logic [PC_W-1:0]       pc;
        inst_class_e           iclass;
        // Zero when nothing is written
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } issue_slot_t;

    // Two slots in program order, a is the older one
    // valid[0] belongs to a, valid[1] to b
    typedef struct packed {
        issue_slot_t a;
        issue_slot_t b;
        logic [1:0]  valid;
    } slot_pair_t;

endpackage

// File: rtl/issue_queue.sv
module issue_queue
    import dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  slot_pair_t i_push,
    input  logic [1:0] i_pop_count,
    output slot_pair_t o_head,
    output logic [1:0] o_credit_return
);

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    issue_slot_t mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;

    logic [1:0] push_count;
    logic       push_a;
    logic       push_b;

    // Slot b only counts alongside slot a
    assign push_a = i_push.valid[0];
    assign push_b = i_push.valid[0] & i_push.valid[1];

    always_comb begin
        case ({push_b, push_a})
            2'b01:   push_count = 2'd1;
            2'b11:   push_count = 2'd2;
            default: push_count = 2'd0;
        endcase
    end

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push_a) begin
            mem[wr_ptr] <= i_push.a;
        end
        // Next entry, wraps with the pointer width
        if (push_b) begin
            mem[wr_ptr + QUEUE_PTR_W'(1)] <= i_push.b;
        end
    end

    //////////////////////////////////////////////////
    // Pointer, occupancy and credit state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            o_credit_return <= 2'd0;
        end else begin
            wr_ptr <= wr_ptr + QUEUE_PTR_W'(push_count);
            rd_ptr <= rd_ptr + QUEUE_PTR_W'(i_pop_count);
            count  <= count + QUEUE_CNT_W'(push_count) - QUEUE_CNT_W'(i_pop_count);
            // One credit back per retired entry, a cycle late
            o_credit_return <= i_pop_count;
        end
    end

    //////////////////////////////////////////////////
    // Head view
    //////////////////////////////////////////////////

    // Two oldest entries, valid by occupancy
    always_comb begin
        o_head.a        = mem[rd_ptr];
        o_head.b        = mem[rd_ptr + QUEUE_PTR_W'(1)];
        o_head.valid[0] = (count != '0);
        o_head.valid[1] = (count >= QUEUE_CNT_W'(2));
    end

endmodule

// File: rtl/pair_hazard_check.sv
module pair_hazard_check
    import dispatch_pkg::*;
(
    input  slot_pair_t i_head,
    output logic       o_pair_ok
);

    //////////////////////////////////////////////////
    // Pair rules
    //////////////////////////////////////////////////

    logic a_not_alu;
    logic both_branch;
    logic b_reads_a;

    // Only a plain ALU op in the older slot may pair
    assign a_not_alu = (i_head.a.iclass != CLASS_ALU);

    // A single branch unit downstream
    assign both_branch = (i_head.a.iclass == CLASS_BRANCH) &&
                         (i_head.b.iclass == CLASS_BRANCH);

    // RAW inside the pair
    // r0 writes are discarded, so no hazard there
    always_comb begin
        b_reads_a = 1'b0;
        if (i_head.a.rd != REG_ZERO) begin
            b_reads_a = (i_head.a.rd == i_head.b.rs1) ||
                        (i_head.a.rd == i_head.b.rs2);
        end
    end

    //////////////////////////////////////////////////
    // Result
    //////////////////////////////////////////////////

    // Valid bits are handled in the selector
    assign o_pair_ok = ~(a_not_alu | both_branch | b_reads_a);

endmodule

// File: rtl/load_use_check.sv
module load_use_check
    import dispatch_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_reset,
    input  slot_pair_t            i_head,
    input  logic                  i_load_issued,
    input  logic [REG_ADDR_W-1:0] i_load_rd,
    output logic                  o_stall_a,
    output logic                  o_stall_b
);

    //////////////////////////////////////////////////
    // Last issued load
    //////////////////////////////////////////////////

    logic                  load_pending;
    logic [REG_ADDR_W-1:0] load_rd;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            load_pending <= 1'b0;
        end else begin
            // A load into r0 leaves nothing to wait for
            load_pending <= i_load_issued && (i_load_rd != REG_ZERO);
        end
    end

    always_ff @(posedge clk) begin
        load_rd <= i_load_rd;
    end

    //////////////////////////////////////////////////
    // Source match per slot
    //////////////////////////////////////////////////

    // Load data arrives one cycle too late for these
    assign o_stall_a = load_pending &&
                       ((i_head.a.rs1 == load_rd) || (i_head.a.rs2 == load_rd));

    assign o_stall_b = load_pending &&
                       ((i_head.b.rs1 == load_rd) || (i_head.b.rs2 == load_rd));

endmodule

// File: rtl/issue_select.sv
module issue_select
    import dispatch_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_reset,
    input  slot_pair_t            i_head,
    input  logic                  i_pair_ok,
    input  logic                  i_stall_a,
    input  logic                  i_stall_b,
    output logic [1:0]            o_pop_count,
    output logic                  o_load_issued,
    output logic [REG_ADDR_W-1:0] o_load_rd,
    output slot_pair_t            o_issue
);

    //////////////////////////////////////////////////
    // Issue count
    //////////////////////////////////////////////////

    logic issue_a;
    logic issue_b;
    logic load_a;
    logic load_b;

    // A stall on a holds b back too, order is kept
    assign issue_a = i_head.valid[0] & ~i_stall_a;
    assign issue_b = issue_a & i_head.valid[1] & ~i_stall_b & i_pair_ok;

    always_comb begin
        if (!issue_a) begin
            o_pop_count = 2'd0;
        end else if (!issue_b) begin
            o_pop_count = 2'd1;
        end else begin
            o_pop_count = 2'd2;
        end
    end

    //////////////////////////////////////////////////
    // Load feedback
    //////////////////////////////////////////////////

    // Non-ALU in a forces single issue, so one load at most
    assign load_a = issue_a && (i_head.a.iclass == CLASS_LOAD);
    assign load_b = issue_b && (i_head.b.iclass == CLASS_LOAD);

    assign o_load_issued = load_a | load_b;
    assign o_load_rd     = load_a ? i_head.a.rd : i_head.b.rd;

    //////////////////////////////////////////////////
    // Issued group register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        o_issue.a <= i_head.a;
        o_issue.b <= i_head.b;
        if (i_reset) begin
            o_issue.valid <= 2'b00;
        end else begin
            o_issue.valid <= {issue_b, issue_a};
        end
    end

endmodule

// File: rtl/dual_issue_top.sv
module dual_issue_top
    import dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  slot_pair_t i_push,
    output logic [1:0] o_credit_return,
    output slot_pair_t o_issue
);

    slot_pair_t            head;
    logic                  pair_ok;
    logic                  stall_a;
    logic                  stall_b;
    logic [1:0]            pop_count;
    logic                  load_issued;
    logic [REG_ADDR_W-1:0] load_rd;

    //////////////////////////////////////////////////
    // Queue
    //////////////////////////////////////////////////

    issue_queue u_queue (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_push          (i_push),
        .i_pop_count     (pop_count),
        .o_head          (head),
        .o_credit_return (o_credit_return)
    );

    //////////////////////////////////////////////////
    // Hazard checks, side by side
    //////////////////////////////////////////////////

    pair_hazard_check u_pair_check (
        .i_head    (head),
        .o_pair_ok (pair_ok)
    );

    load_use_check u_load_use (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_head        (head),
        .i_load_issued (load_issued),
        .i_load_rd     (load_rd),
        .o_stall_a     (stall_a),
        .o_stall_b     (stall_b)
    );

    // Selector closes the loop back to queue and load check
    issue_select u_select (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_head        (head),
        .i_pair_ok     (pair_ok),
        .i_stall_a     (stall_a),
        .i_stall_b     (stall_b),
        .o_pop_count   (pop_count),
        .o_load_issued (load_issued),
        .o_load_rd     (load_rd),
        .o_issue       (o_issue)
    );

endmodule

// File: tests/tb_dual_issue.sv
module tb_dual_issue
    import dispatch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic       clk;
    logic       i_reset;
    slot_pair_t push;
    logic [1:0] credit_return;
    slot_pair_t issue;

    // Parsed tests, one entry per test
    string       test_name[$];
    int          test_first[$];
    int          test_len[$];
    int          group_first[$];
    int          group_len[$];
    // Instructions and expected group sizes of all tests
    issue_slot_t prog[$];
    int          groups[$];

    int credits;
    int credit_sum;
    int issued_total;
    int seed;
    bit loaded;

    dual_issue_top UUT (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_push          (push),
        .o_credit_return (credit_return),
        .o_issue         (issue)
    );

    always begin
        #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s: expected %0d, actual %0d",
                                label, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // Test file
    //////////////////////////////////////////////////

    task automatic decode_class(input string name, output inst_class_e cls);
        cls = CLASS_ALU;
        case (name)
            "alu":    cls = CLASS_ALU;
            "muldiv": cls = CLASS_MULDIV;
            "load":   cls = CLASS_LOAD;
            "store":  cls = CLASS_STORE;
            "branch": cls = CLASS_BRANCH;
            default:  abort_run($sformatf("Unknown instruction class %s in test file", name));
        endcase
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        int          c;
        int          rd;
        int          rs1;
        int          rs2;
        int          ngroups;
        int          g;
        int          sum;
        string       word;
        string       name;
        string       cls_name;
        inst_class_e cls;
        issue_slot_t slot;

        fd = $fopen("tests/dispatch_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tests/dispatch_tests.txt");
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word.substr(0, 0) == "#") begin
                // Rest of a comment line
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (word == "test") begin
                n = $fscanf(fd, "%s", name);
                test_name.push_back(name);
                test_first.push_back(prog.size());
                test_len.push_back(0);
            end else if (word == "inst") begin
                n = $fscanf(fd, "%s %d %d %d", cls_name, rd, rs1, rs2);
                if (n != 4 || test_name.size() == 0) begin
                    abort_run("Malformed instruction line in test file");
                end
                decode_class(cls_name, cls);
                // Program order sets the pc
                slot.pc     = 32'h0000_1000 + 32'(4 * prog.size());
                slot.iclass = cls;
                slot.rd     = REG_ADDR_W'(rd);
                slot.rs1    = REG_ADDR_W'(rs1);
                slot.rs2    = REG_ADDR_W'(rs2);
                prog.push_back(slot);
                test_len[test_len.size() - 1] += 1;
            end else if (word == "expect") begin
                n = $fscanf(fd, "%d", ngroups);
                group_first.push_back(groups.size());
                group_len.push_back(ngroups);
                sum = 0;
                for (int k = 0; k < ngroups; k++) begin
                    n = $fscanf(fd, "%d", g);
                    groups.push_back(g);
                    sum += g;
                end
                if (sum != test_len[test_len.size() - 1]) begin
                    abort_run($sformatf("Expected groups of test %s do not cover it", name));
                end
            end else begin
                abort_run($sformatf("Unknown keyword %s in test file", word));
            end
        end
        $fclose(fd);
        if (group_len.size() != test_name.size() || test_name.size() == 0) begin
            abort_run("Test file has a test without an expect line");
        end
        loaded = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Driver and scoreboard
    //////////////////////////////////////////////////

    task automatic drive_push(input int idx, input int npush);
        push = '0;
        if (npush >= 1) begin
            push.a        = prog[idx];
            push.valid[0] = 1'b1;
        end
        if (npush == 2) begin
            push.b        = prog[idx + 1];
            push.valid[1] = 1'b1;
        end
    endtask

    task automatic verify_idle(input string label);
        check_value({label, " credit return"}, 0, 32'(credit_return));
        check_value({label, " issue valid"}, 0, 32'(issue.valid));
    endtask

    task automatic compare_slot(input string label, input int idx, input issue_slot_t slot);
        check_value({label, " pc"}, prog[idx].pc, slot.pc);
        check_value({label, " class"}, 32'(prog[idx].iclass), 32'(slot.iclass));
        check_value({label, " rd"}, 32'(prog[idx].rd), 32'(slot.rd));
        check_value({label, " rs1"}, 32'(prog[idx].rs1), 32'(slot.rs1));
        check_value({label, " rs2"}, 32'(prog[idx].rs2), 32'(slot.rs2));
    endtask

    task automatic run_test(input int t);
        string name;
        int    first;
        int    len;
        int    gfirst;
        int    glen;
        int    pushed;
        int    issued;
        int    gidx;
        int    keep;
        int    room;
        int    lo;
        int    hi;
        int    npush;
        int    size;
        bit    started;

        name    = test_name[t];
        first   = test_first[t];
        len     = test_len[t];
        gfirst  = group_first[t];
        glen    = group_len[t];
        pushed  = 0;
        issued  = 0;
        gidx    = 0;
        started = 1'b0;

        while (gidx < glen) begin
            // Entries left if the head pair leaves on the next edge
            keep = pushed - issued;
            keep = (keep > 2) ? keep - 2 : 0;
            lo   = (keep >= 2) ? 0 : 2 - keep;
            if (lo > len - pushed) begin
                lo = len - pushed;
            end
            hi = (len - pushed > 2) ? 2 : len - pushed;
            // Free entries as seen from the issued groups
            room = QUEUE_DEPTH - (pushed - issued);
            if (hi > room) begin
                hi = room;
            end
            if (lo > hi) begin
                lo = hi;
            end
            npush = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
            credits -= npush;
            if (credits < 0) begin
                abort_run("Credit counter went below zero");
            end
            drive_push(first + pushed, npush);
            pushed += npush;

            @(posedge clk);
            #5;
            credits    += int'(credit_return);
            credit_sum += int'(credit_return);
            if (issue.valid == 2'b10) begin
                abort_run($sformatf("Test %s issued slot b without slot a", name));
            end
            size = int'(issue.valid[0]) + int'(issue.valid[1]);
            if (size != 0) begin
                started = 1'b1;
            end
            // Zero groups count only once the test is flowing
            if (started) begin
                check_value($sformatf("%s group %0d size", name, gidx),
                            groups[gfirst + gidx], size);
                check_value($sformatf("%s group %0d credit return", name, gidx),
                            groups[gfirst + gidx], 32'(credit_return));
                if (issue.valid[0]) begin
                    compare_slot($sformatf("%s group %0d slot a", name, gidx),
                                 first + issued, issue.a);
                end
                if (issue.valid[1]) begin
                    compare_slot($sformatf("%s group %0d slot b", name, gidx),
                                 first + issued + 1, issue.b);
                end
                issued       += size;
                issued_total += size;
                gidx++;
            end else begin
                check_value($sformatf("%s idle credit return", name),
                            0, 32'(credit_return));
            end
        end
        drive_push(first, 0);
        check_value($sformatf("%s instructions issued", name), len, issued);
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        i_reset      = 1'b1;
        push         = '0;
        credits      = QUEUE_DEPTH;
        credit_sum   = 0;
        issued_total = 0;
        seed         = 32'h1284_992c;
        load_tests();

        repeat (5) begin
            @(posedge clk);
            #5;
            verify_idle("reset");
        end
        i_reset = 1'b0;
        @(posedge clk);
        #5;
        verify_idle("after_reset");

        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end

        check_value("run credits returned", issued_total, credit_sum);
        $display("Regression passed");
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        // 40 cycles per instruction over the whole run
        limit = 40 * prog.size();
        repeat (limit) @(posedge clk);
        abort_run($sformatf("Run timed out after %0d cycles before the tests finished", limit));
    end

endmodule

// File: tests/dispatch_tests.txt
# Columns: test <name> | inst <class> <rd> <rs1> <rs2> | expect <count> <group sizes>
# Group sizes in issue order, a 0 is a cycle with nothing issued
test alu_pairs
inst alu 1 2 3
inst alu 4 5 6
inst alu 7 8 9
inst alu 10 11 12
inst alu 13 14 15
inst alu 16 17 18
expect 3 2 2 2
test raw_split
inst alu 5 1 2
inst alu 6 3 5
inst alu 7 6 1
inst alu 8 1 2
expect 3 1 1 2
test raw_r0
inst alu 0 1 2
inst alu 6 0 0
inst alu 0 4 4
inst alu 7 0 3
expect 2 2 2
test branch_pair
inst branch 0 1 2
inst branch 0 3 4
inst alu 5 1 2
inst branch 0 6 7
expect 3 1 1 2
test non_alu_slot_a
inst muldiv 3 1 2
inst alu 4 1 2
inst store 0 8 9
inst store 0 10 11
inst alu 12 1 2
expect 4 1 2 1 1
test load_use
inst alu 1 2 3
inst load 4 2 0
inst alu 5 4 6
inst alu 7 8 9
inst load 10 1 1
inst alu 11 2 3
inst alu 12 10 0
expect 6 2 0 2 1 1 1
test load_r0
inst load 0 1 1
inst alu 3 0 0
inst alu 5 6 7
expect 2 1 2

// File: filelist.f
rtl/dispatch_pkg.sv
rtl/issue_queue.sv
rtl/pair_hazard_check.sv
rtl/load_use_check.sv
rtl/issue_select.sv
rtl/dual_issue_top.sv
tests/tb_dual_issue.sv

// File: Makefile
TOP := tb_dual_issue

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

# Exit status of the binary is the regression result
sim:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
